/* design/bus_map_pkg.sv */
package bus_map_pkg;

    //////////////////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////////////////
    localparam int DATA_W = 8;   // Z80 data bus
    localparam int ADDR_W = 8;   // Low byte of the I/O address

    //////////////////////////////////////////////////////////////
    // I/O register map
    //////////////////////////////////////////////////////////////

    // Channel k: period at base + 2k, volume at base + 2k + 1
    localparam logic [ADDR_W-1:0] IO_CHAN_BASE = 8'hE0;

    localparam logic [ADDR_W-1:0] IO_DAC  = 8'hEC;   // 8-bit audio DAC
    localparam logic [ADDR_W-1:0] IO_BEEP = 8'hFC;   // Cassette beep, bit 0 only

    //////////////////////////////////////////////////////////////
    // Strobe synchronizer
    //////////////////////////////////////////////////////////////
    localparam int SYNC_STAGES = 3;

endpackage

/* design/audio_pkg.sv */
package audio_pkg;

    //////////////////////////////////////////////////////////////
    // Tone channels
    //////////////////////////////////////////////////////////////
    localparam int NUM_CHANNELS = 4;
    localparam int PERIOD_W     = 8;
    localparam int VOLUME_W     = 4;
    localparam int LEVEL_W      = 10;   // Volume times 64

    // Clocks per period tick
    localparam int TONE_PRESCALE = 16;
    localparam int PRESCALE_W    = $clog2(TONE_PRESCALE);

    //////////////////////////////////////////////////////////////
    // Stereo mix
    //////////////////////////////////////////////////////////////
    localparam int MIX_W = 14;

    // Even channels lean left, odd channels lean right
    localparam int unsigned PAN_LEFT  [NUM_CHANNELS] = '{2, 1, 2, 1};
    localparam int unsigned PAN_RIGHT [NUM_CHANNELS] = '{1, 2, 1, 2};

    localparam int DAC_SHIFT  = 4;      // DAC byte lands in mix bits 11:4
    localparam int BEEP_LEVEL = 1023;   // Added to both sides

    //////////////////////////////////////////////////////////////
    // PWM output
    //////////////////////////////////////////////////////////////
    localparam int PWM_W = 10;   // Frame is 2**PWM_W clocks

endpackage

/* design/io_bus_port.sv */
`timescale 1ns/10ps

module io_bus_port
    import bus_map_pkg::*;
    import audio_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,

    input  logic [ADDR_W-1:0]       addr,
    input  logic [DATA_W-1:0]       wr_data,
    input  logic                    wr_n,
    input  logic                    rd_n,
    input  logic                    iorq_n,

    input  logic [PERIOD_W-1:0]     period [NUM_CHANNELS],
    input  logic [VOLUME_W-1:0]     volume [NUM_CHANNELS],

    output logic [DATA_W-1:0]       rd_data,
    output logic                    rd_oe,
    output logic [DATA_W-1:0]       wr_value,
    output logic [NUM_CHANNELS-1:0] period_wr,
    output logic [NUM_CHANNELS-1:0] volume_wr,
    output logic [DATA_W-1:0]       dac_value,
    output logic                    beep
);

    logic [SYNC_STAGES-1:0]  wr_n_sync;
    logic                    wr_n_last;
    logic                    wr_fall;
    logic                    write_cycle;

    logic [NUM_CHANNELS-1:0] chan_period_hit;
    logic [NUM_CHANNELS-1:0] chan_volume_hit;
    logic                    dac_hit;
    logic                    beep_hit;
    logic                    mapped;

    logic                    dac_wr;
    logic                    beep_wr;

    //////////////////////////////////////////////////////////////
    // Write strobe synchronizer and edge detect
    //////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_n_sync <= '1;   // Bus idles with wr_n high
            wr_n_last <= 1'b1;
        end else begin
            wr_n_sync <= {wr_n_sync[SYNC_STAGES-2:0], wr_n};
            wr_n_last <= wr_n_sync[SYNC_STAGES-1];
        end
    end

    assign wr_fall     = wr_n_last && !wr_n_sync[SYNC_STAGES-1];
    assign write_cycle = wr_fall && !iorq_n;

    // Data is stable for as long as wr_n stays low
    always_ff @(posedge clk) begin
        if (!wr_n)
            wr_value <= wr_data;
    end

    //////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////
    always_comb begin
        chan_period_hit = '0;
        chan_volume_hit = '0;
        for (int k = 0; k < NUM_CHANNELS; k++) begin
            chan_period_hit[k] = addr == ADDR_W'(IO_CHAN_BASE + 2 * k);
            chan_volume_hit[k] = addr == ADDR_W'(IO_CHAN_BASE + 2 * k + 1);
        end
    end

    assign dac_hit  = addr == IO_DAC;
    assign beep_hit = addr == IO_BEEP;
    assign mapped   = (|chan_period_hit) || (|chan_volume_hit) || dac_hit || beep_hit;

    // One-cycle strobes, aligned with wr_value
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            period_wr <= '0;
            volume_wr <= '0;
            dac_wr    <= 1'b0;
            beep_wr   <= 1'b0;
        end else begin
            period_wr <= chan_period_hit & {NUM_CHANNELS{write_cycle}};
            volume_wr <= chan_volume_hit & {NUM_CHANNELS{write_cycle}};
            dac_wr    <= dac_hit && write_cycle;
            beep_wr   <= beep_hit && write_cycle;
        end
    end

    //////////////////////////////////////////////////////////////
    // DAC and beep registers
    //////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dac_value <= '0;
            beep      <= 1'b0;
        end else begin
            if (dac_wr)  dac_value <= wr_value;
            if (beep_wr) beep      <= wr_value[0];
        end
    end

    //////////////////////////////////////////////////////////////
    // Readback
    //////////////////////////////////////////////////////////////
    always_comb begin
        rd_data = '0;
        for (int k = 0; k < NUM_CHANNELS; k++) begin
            if (chan_period_hit[k]) rd_data = DATA_W'(period[k]);
            if (chan_volume_hit[k]) rd_data = DATA_W'(volume[k]);   // Zero-extended
        end
        if (dac_hit)  rd_data = dac_value;
        if (beep_hit) rd_data = DATA_W'(beep);
    end

    assign rd_oe = !iorq_n && !rd_n && mapped;

endmodule

/* design/tone_channel.sv */
`timescale 1ns/10ps

module tone_channel
    import bus_map_pkg::*;
    import audio_pkg::*;
(
    input  logic                clk,
    input  logic                reset,

    input  logic [DATA_W-1:0]   wr_value,
    input  logic                period_wr,
    input  logic                volume_wr,

    output logic [PERIOD_W-1:0] period,
    output logic [VOLUME_W-1:0] volume,
    output logic [LEVEL_W-1:0]  level
);

    logic [PRESCALE_W-1:0] prescale_cnt;
    logic                  tick;
    logic [PERIOD_W-1:0]   tone_cnt;
    logic                  phase;
    logic                  hold_high;

    // Registers written by the bus port
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            period <= '0;
            volume <= '0;
        end else begin
            if (period_wr) period <= wr_value[PERIOD_W-1:0];
            if (volume_wr) volume <= wr_value[VOLUME_W-1:0];
        end
    end

    //////////////////////////////////////////////////////////////
    // Square-wave generator
    //////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            prescale_cnt <= '0;
        else if (tick)
            prescale_cnt <= '0;
        else
            prescale_cnt <= prescale_cnt + 1'b1;
    end

    assign tick      = prescale_cnt == PRESCALE_W'(TONE_PRESCALE - 1);
    assign hold_high = period == '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tone_cnt <= '0;
            phase    <= 1'b1;
        end else if (hold_high) begin
            tone_cnt <= '0;   // Steady level
            phase    <= 1'b1;
        end else if (tick) begin
            // Half period is period + 1 ticks
            if (tone_cnt >= period) begin
                tone_cnt <= '0;
                phase    <= !phase;
            end else begin
                tone_cnt <= tone_cnt + 1'b1;
            end
        end
    end

    // Level is volume * 64 while the phase is high
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            level <= '0;
        else if (phase || hold_high)
            level <= {volume, {(LEVEL_W - VOLUME_W){1'b0}}};
        else
            level <= '0;
    end

endmodule

/* design/stereo_mixer.sv */
`timescale 1ns/10ps

module stereo_mixer
    import bus_map_pkg::*;
    import audio_pkg::*;
(
    input  logic               clk,
    input  logic               reset,

    input  logic [LEVEL_W-1:0] level [NUM_CHANNELS],
    input  logic [DATA_W-1:0]  dac_value,
    input  logic               beep,

    output logic [MIX_W-1:0]   mix_l,
    output logic [MIX_W-1:0]   mix_r
);

    logic [MIX_W-1:0] sum_l;
    logic [MIX_W-1:0] sum_r;
    logic [MIX_W-1:0] dac_term;
    logic [MIX_W-1:0] beep_term;

    assign dac_term  = MIX_W'(dac_value) << DAC_SHIFT;
    assign beep_term = beep ? MIX_W'(BEEP_LEVEL) : '0;

    //////////////////////////////////////////////////////////////
    // Weighted sum per side
    //////////////////////////////////////////////////////////////
    always_comb begin
        sum_l = dac_term + beep_term;
        sum_r = dac_term + beep_term;
        for (int k = 0; k < NUM_CHANNELS; k++) begin
            sum_l = sum_l + MIX_W'(level[k] * PAN_LEFT[k]);
            sum_r = sum_r + MIX_W'(level[k] * PAN_RIGHT[k]);
        end
    end

    // Worst case stays below 2**MIX_W
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mix_l <= '0;
            mix_r <= '0;
        end else begin
            mix_l <= sum_l;
            mix_r <= sum_r;
        end
    end

endmodule

/* design/pwm_dac.sv */
`timescale 1ns/10ps

module pwm_dac
    import audio_pkg::*;
(
    input  logic             clk,
    input  logic             reset,

    input  logic [MIX_W-1:0] mix_l,
    input  logic [MIX_W-1:0] mix_r,

    output logic             audio_l,
    output logic             audio_r
);

    logic [PWM_W-1:0] frame_cnt;
    logic [PWM_W-1:0] cmp_l;
    logic [PWM_W-1:0] cmp_r;
    logic [PWM_W-1:0] cmp_l_now;
    logic [PWM_W-1:0] cmp_r_now;
    logic             frame_start;

    assign frame_start = frame_cnt == '0;

    // New compare values take effect on the first clock of the frame
    assign cmp_l_now = frame_start ? mix_l[MIX_W-1 -: PWM_W] : cmp_l;
    assign cmp_r_now = frame_start ? mix_r[MIX_W-1 -: PWM_W] : cmp_r;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame_cnt <= '0;
            cmp_l     <= '0;
            cmp_r     <= '0;
            audio_l   <= 1'b0;
            audio_r   <= 1'b0;
        end else begin
            frame_cnt <= frame_cnt + 1'b1;   // Wraps every 2**PWM_W clocks
            cmp_l     <= cmp_l_now;
            cmp_r     <= cmp_r_now;
            audio_l   <= frame_cnt < cmp_l_now;
            audio_r   <= frame_cnt < cmp_r_now;
        end
    end

endmodule

/* design/aqp_audio.sv */
`timescale 1ns/10ps

module aqp_audio
    import bus_map_pkg::*;
    import audio_pkg::*;
(
    input  logic              clk,
    input  logic              reset,

    // Z80 I/O bus
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wr_data,
    input  logic              wr_n,
    input  logic              rd_n,
    input  logic              iorq_n,
    output logic [DATA_W-1:0] rd_data,
    output logic              rd_oe,

    // PWM audio
    output logic              audio_l,
    output logic              audio_r
);

    logic [DATA_W-1:0]       wr_value;
    logic [NUM_CHANNELS-1:0] period_wr;
    logic [NUM_CHANNELS-1:0] volume_wr;
    logic [PERIOD_W-1:0]     period [NUM_CHANNELS];
    logic [VOLUME_W-1:0]     volume [NUM_CHANNELS];
    logic [LEVEL_W-1:0]      level  [NUM_CHANNELS];
    logic [DATA_W-1:0]       dac_value;
    logic                    beep;
    logic [MIX_W-1:0]        mix_l;
    logic [MIX_W-1:0]        mix_r;

    //////////////////////////////////////////////////////////////
    // Bus port
    //////////////////////////////////////////////////////////////
    io_bus_port i_io_bus_port (
        .clk       (clk),
        .reset     (reset),
        .addr      (addr),
        .wr_data   (wr_data),
        .wr_n      (wr_n),
        .rd_n      (rd_n),
        .iorq_n    (iorq_n),
        .period    (period),
        .volume    (volume),
        .rd_data   (rd_data),
        .rd_oe     (rd_oe),
        .wr_value  (wr_value),
        .period_wr (period_wr),
        .volume_wr (volume_wr),
        .dac_value (dac_value),
        .beep      (beep)
    );

    //////////////////////////////////////////////////////////////
    // Tone channels
    //////////////////////////////////////////////////////////////
    for (genvar k = 0; k < NUM_CHANNELS; k++) begin : g_chan
        tone_channel i_tone_channel (
            .clk       (clk),
            .reset     (reset),
            .wr_value  (wr_value),
            .period_wr (period_wr[k]),
            .volume_wr (volume_wr[k]),
            .period    (period[k]),
            .volume    (volume[k]),
            .level     (level[k])
        );
    end

    //////////////////////////////////////////////////////////////
    // Mix and PWM output
    //////////////////////////////////////////////////////////////
    stereo_mixer i_stereo_mixer (
        .clk       (clk),
        .reset     (reset),
        .level     (level),
        .dac_value (dac_value),
        .beep      (beep),
        .mix_l     (mix_l),
        .mix_r     (mix_r)
    );

    pwm_dac i_pwm_dac (
        .clk     (clk),
        .reset   (reset),
        .mix_l   (mix_l),
        .mix_r   (mix_r),
        .audio_l (audio_l),
        .audio_r (audio_r)
    );

endmodule

/* testbench/aqp_audio_props.sv */
`timescale 1ns/10ps

module aqp_audio_props
    import bus_map_pkg::*;
    import audio_pkg::*;
(
    input logic                    clk,
    input logic                    reset,
    input logic [ADDR_W-1:0]       addr,
    input logic                    rd_n,
    input logic                    iorq_n,
    input logic                    rd_oe,
    input logic [NUM_CHANNELS-1:0] period_wr,
    input logic [NUM_CHANNELS-1:0] volume_wr,
    input logic                    audio_l,
    input logic                    audio_r
);

    int   fail_count = 0;
    logic mapped;
    logic read_hit;

    assign mapped = (addr >= IO_CHAN_BASE && addr < IO_CHAN_BASE + 2 * NUM_CHANNELS)
                    || addr == IO_DAC || addr == IO_BEEP;
    assign read_hit = !iorq_n && !rd_n && mapped;

    ////////////////////////////////////////////////////////////
    // Bus side
    ////////////////////////////////////////////////////////////
    a_rd_oe: assert property (@(posedge clk) rd_oe == read_hit)
        else begin
            $error("rd_oe differs from the decoded I/O read");
            fail_count++;
        end

    // Strobes last one cycle
    a_strobe_pulse: assert property (@(posedge clk) disable iff (reset)
        (|{period_wr, volume_wr}) |=> {period_wr, volume_wr} == '0)
        else begin
            $error("Write strobe held for more than one cycle");
            fail_count++;
        end

    ////////////////////////////////////////////////////////////
    // PWM side
    ////////////////////////////////////////////////////////////
    a_audio_low_in_reset: assert property (@(posedge clk) reset |-> !audio_l && !audio_r)
        else begin
            $error("PWM output high during reset");
            fail_count++;
        end

    a_audio_stable_in_reset: assert property (@(posedge clk)
        reset |=> $stable(audio_l) && $stable(audio_r))
        else begin
            $error("PWM output changed while reset was high");
            fail_count++;
        end

endmodule

/* testbench/aqp_audio_tb.sv */
`timescale 1ns/10ps

module aqp_audio_tb
    import bus_map_pkg::*;
    import audio_pkg::*;
();

    localparam int FRAME_CLKS  = 1 << PWM_W;
    localparam int CNT_SHIFT   = MIX_W - PWM_W;   // Top PWM_W bits of the mix
    localparam int TONE_FRAMES = 16;
    localparam int TONE_PERIOD = 127;             // Half wave spans two frames
    // Reset check, two static mixes, tone settle and tone frames, then margin
    localparam int RUN_FRAMES  = 1 + 4 + 4 + 3 + TONE_FRAMES + 4;
    localparam int RUN_NS      = (RUN_FRAMES * FRAME_CLKS + 2000) * 8;

    logic              clk;
    logic              reset;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wr_data;
    logic              wr_n;
    logic              rd_n;
    logic              iorq_n;
    logic [DATA_W-1:0] rd_data;
    logic              rd_oe;
    logic              audio_l;
    logic              audio_r;

    // Reference model of every register
    logic [PERIOD_W-1:0] model_period [NUM_CHANNELS];
    logic [VOLUME_W-1:0] model_volume [NUM_CHANNELS];
    logic [DATA_W-1:0]   model_dac;
    logic                model_beep;

    logic [15:0] lfsr_state;
    int          value_errors;
    int          other_errors;

    aqp_audio i_aqp_audio (
        .clk     (clk),
        .reset   (reset),
        .addr    (addr),
        .wr_data (wr_data),
        .wr_n    (wr_n),
        .rd_n    (rd_n),
        .iorq_n  (iorq_n),
        .rd_data (rd_data),
        .rd_oe   (rd_oe),
        .audio_l (audio_l),
        .audio_r (audio_r)
    );

    bind aqp_audio aqp_audio_props i_aqp_audio_props (
        .clk       (clk),
        .reset     (reset),
        .addr      (addr),
        .rd_n      (rd_n),
        .iorq_n    (iorq_n),
        .rd_oe     (rd_oe),
        .period_wr (period_wr),
        .volume_wr (volume_wr),
        .audio_l   (audio_l),
        .audio_r   (audio_r)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [7:0] random_bits(input int n);
        logic [7:0] value;
        logic       fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            value      = {value[6:0], fb};
        end
        return value;
    endfunction

    function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] a);
        logic [DATA_W-1:0] value;
        value = '0;
        for (int k = 0; k < NUM_CHANNELS; k++) begin
            if (a == ADDR_W'(IO_CHAN_BASE + 2 * k))     value = DATA_W'(model_period[k]);
            if (a == ADDR_W'(IO_CHAN_BASE + 2 * k + 1)) value = DATA_W'(model_volume[k]);
        end
        if (a == IO_DAC)  value = model_dac;
        if (a == IO_BEEP) value = DATA_W'(model_beep);
        return value;
    endfunction

    function automatic bit is_mapped(input logic [ADDR_W-1:0] a);
        return (a >= IO_CHAN_BASE && a < IO_CHAN_BASE + 2 * NUM_CHANNELS)
               || a == IO_DAC || a == IO_BEEP;
    endfunction

    // Weighted sum, optionally leaving one channel's level out
    function automatic int predicted_mix(input bit left, input int absent_chan);
        int sum;
        sum = int'(model_dac) << DAC_SHIFT;
        if (model_beep)
            sum += BEEP_LEVEL;
        for (int k = 0; k < NUM_CHANNELS; k++) begin
            if (k != absent_chan)
                sum += int'(model_volume[k]) * 64 * (left ? PAN_LEFT[k] : PAN_RIGHT[k]);
        end
        return sum;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected)
        else begin
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, actual, expected,
                     $time);
            value_errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Bus cycles
    ////////////////////////////////////////////////////////////
    task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        @(posedge clk);
        addr    <= a;
        wr_data <= d;
        iorq_n  <= 1'b0;
        @(posedge clk);
        wr_n <= 1'b0;
        repeat (5) @(posedge clk);
        wr_n <= 1'b1;
        @(posedge clk);
        iorq_n <= 1'b1;
        repeat (4) @(posedge clk);   // Synchronizer back to idle
        for (int k = 0; k < NUM_CHANNELS; k++) begin
            if (a == ADDR_W'(IO_CHAN_BASE + 2 * k))     model_period[k] = d[PERIOD_W-1:0];
            if (a == ADDR_W'(IO_CHAN_BASE + 2 * k + 1)) model_volume[k] = d[VOLUME_W-1:0];
        end
        if (a == IO_DAC)  model_dac  = d;
        if (a == IO_BEEP) model_beep = d[0];
    endtask

    task automatic bus_read_check(input logic [ADDR_W-1:0] a);
        @(posedge clk);
        addr   <= a;
        iorq_n <= 1'b0;
        rd_n   <= 1'b0;
        @(negedge clk);
        check_value("rd_oe", rd_oe, is_mapped(a));
        if (is_mapped(a))
            check_value("rd_data", rd_data, expected_read(a));
        @(posedge clk);
        rd_n   <= 1'b1;
        iorq_n <= 1'b1;
    endtask

    task automatic read_all_registers;
        for (int k = 0; k < 2 * NUM_CHANNELS; k++)
            bus_read_check(ADDR_W'(IO_CHAN_BASE + k));
        bus_read_check(IO_DAC);
        bus_read_check(IO_BEEP);
    endtask

    ////////////////////////////////////////////////////////////
    // Duty measurement
    ////////////////////////////////////////////////////////////

    // Stops on the negedge just before counter value zero reaches the outputs
    task automatic align_frame;
        int guard;
        guard = 0;
        @(negedge clk);
        while (i_aqp_audio.i_pwm_dac.frame_cnt != '0 && guard < FRAME_CLKS) begin
            @(negedge clk);
            guard++;
        end
        assert (i_aqp_audio.i_pwm_dac.frame_cnt == '0)
        else begin
            $display("PWM frame start not found within one frame");
            other_errors++;
        end
    endtask

    task automatic measure_frame(output int high_l, output int high_r);
        high_l = 0;
        high_r = 0;
        repeat (FRAME_CLKS) begin
            @(negedge clk);
            high_l += audio_l;
            high_r += audio_r;
        end
    endtask

    task automatic check_static_mix;
        int high_l;
        int high_r;
        repeat (2 * FRAME_CLKS) @(negedge clk);   // Mixer and one old frame
        align_frame();
        measure_frame(high_l, high_r);
        check_value("audio_l high count", high_l, predicted_mix(1, -1) >> CNT_SHIFT);
        check_value("audio_r high count", high_r, predicted_mix(0, -1) >> CNT_SHIFT);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int high_l;
        int high_r;
        int tone_chan;
        int with_l;
        int without_l;
        bit seen_with;
        bit seen_without;
        int prop_errors;
        clk          = 1'b0;
        reset        = 1'b1;
        addr         = '0;
        wr_data      = '0;
        wr_n         = 1'b1;
        rd_n         = 1'b1;
        iorq_n       = 1'b1;
        lfsr_state   = 16'd19135;
        value_errors = 0;
        other_errors = 0;
        seen_with    = 1'b0;
        seen_without = 1'b0;
        for (int k = 0; k < NUM_CHANNELS; k++) begin
            model_period[k] = '0;
            model_volume[k] = '0;
        end
        model_dac  = '0;
        model_beep = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Idle state after reset
        @(negedge clk);
        check_value("rd_oe", rd_oe, 0);
        measure_frame(high_l, high_r);
        check_value("audio_l high count", high_l, 0);
        check_value("audio_r high count", high_r, 0);
        read_all_registers();
        bus_read_check(8'hE8);   // Just past the channel block
        bus_read_check(8'h00);

        // Random register contents
        for (int k = 0; k < 2 * NUM_CHANNELS; k++)
            bus_write(ADDR_W'(IO_CHAN_BASE + k), random_bits(8));
        bus_write(IO_DAC, random_bits(8));
        bus_write(IO_BEEP, random_bits(8));
        read_all_registers();

        // Steady levels only
        for (int k = 0; k < NUM_CHANNELS; k++) begin
            bus_write(ADDR_W'(IO_CHAN_BASE + 2 * k), 8'h00);
            bus_write(ADDR_W'(IO_CHAN_BASE + 2 * k + 1), random_bits(4));
        end
        bus_write(IO_DAC, random_bits(8));
        bus_write(IO_BEEP, 8'h00);
        check_static_mix();

        bus_write(IO_BEEP, 8'h01);
        check_static_mix();

        // One channel toggling, sampled once per frame
        tone_chan = random_bits(2);
        bus_write(ADDR_W'(IO_CHAN_BASE + 2 * tone_chan + 1), random_bits(3) | 8'h08);
        bus_write(ADDR_W'(IO_CHAN_BASE + 2 * tone_chan), TONE_PERIOD);
        with_l    = predicted_mix(1, -1) >> CNT_SHIFT;
        without_l = predicted_mix(1, tone_chan) >> CNT_SHIFT;
        repeat (2 * FRAME_CLKS) @(negedge clk);
        align_frame();
        repeat (TONE_FRAMES) begin
            measure_frame(high_l, high_r);
            assert (high_l == with_l || high_l == without_l)
            else begin
                $display("** Error: audio_l high count = 0x%0h, expected 0x%0h or 0x%0h",
                         high_l, with_l, without_l);
                value_errors++;
            end
            seen_with    |= high_l == with_l;
            seen_without |= high_l == without_l;
        end
        assert (seen_with && seen_without)
        else begin
            $display("Tone channel %0d did not alternate the left mix", tone_chan);
            other_errors++;
        end

        prop_errors = i_aqp_audio.i_aqp_audio_props.fail_count;
        $display("Value errors: %0d, other errors: %0d, property failures: %0d",
                 value_errors, other_errors, prop_errors);
        if (value_errors + other_errors + prop_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(RUN_NS);
        $display("Watchdog expired after %0d ns before the run finished", RUN_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* aqp_audio.f */
design/bus_map_pkg.sv
design/audio_pkg.sv
design/io_bus_port.sv
design/tone_channel.sv
design/stereo_mixer.sv
design/pwm_dac.sv
design/aqp_audio.sv
testbench/aqp_audio_props.sv
testbench/aqp_audio_tb.sv

/* Bender.yml */
package:
  name: aqp_audio

sources:
  - files:
      - design/bus_map_pkg.sv
      - design/audio_pkg.sv
      - design/io_bus_port.sv
      - design/tone_channel.sv
      - design/stereo_mixer.sv
      - design/pwm_dac.sv
      - design/aqp_audio.sv
  - target: test
    files:
      - testbench/aqp_audio_props.sv
      - testbench/aqp_audio_tb.sv
